/* logic/soc_macros.svh */
`ifndef SOC_MACROS_SVH
`define SOC_MACROS_SVH

// bus widths
`define SOC_ADDR_W 32
`define SOC_DATA_W 32
`define SOC_STRB_W 4

// four 256 MB windows, top address nibble
`define SOC_WIN_COUNT 4

// on-chip ram depth in words
`define SOC_RAM_WORDS 256

// status display
`define SOC_PAGE_COUNT 16
`define SOC_PATTERN_A 8'hAA
`define SOC_PATTERN_B 8'h55
`define SOC_PATTERN_C 8'hF0
`define SOC_PATTERN_D 8'h0F

`endif

/* logic/soc_pkg.sv */
`include "soc_macros.svh"

package soc_pkg;

    // one address word, two views
    typedef union packed {
        logic [`SOC_ADDR_W-1:0] raw;      // slaves
        struct packed {
            logic [3:0]             win;  // window select
            logic [`SOC_ADDR_W-5:0] offset;
        } f;                              // interconnect
    } bus_addr_u;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'd0,
        RESP_SLVERR = 2'd2,
        RESP_DECERR = 2'd3
    } resp_e;

    // address and data of a write travel together
    typedef struct packed {
        bus_addr_u              addr;
        logic [`SOC_DATA_W-1:0] data;
        logic [`SOC_STRB_W-1:0] strb;
    } wr_req_t;

    typedef struct packed {
        resp_e resp;
    } wr_resp_t;

    typedef struct packed {
        bus_addr_u addr;
    } rd_req_t;

    typedef struct packed {
        logic [`SOC_DATA_W-1:0] data;
        resp_e                  resp;
    } rd_resp_t;

    typedef struct packed {
        logic [7:0] wr_count;
        logic [7:0] rd_count;
        logic [7:0] err_count;
    } bus_stats_t;

endpackage

/* logic/bus_interconnect.sv */
`timescale 1ns/1ps
`include "soc_macros.svh"

module bus_interconnect import soc_pkg::*; (
    input  logic                      sys_clk,
    input  logic                      rst,
    input  wr_req_t                   wr_req,
    input  logic                      wr_req_valid,
    output logic                      wr_req_ready,
    output wr_resp_t                  wr_resp,
    output logic                      wr_resp_valid,
    input  logic                      wr_resp_ready,
    input  rd_req_t                   rd_req,
    input  logic                      rd_req_valid,
    output logic                      rd_req_ready,
    output rd_resp_t                  rd_resp,
    output logic                      rd_resp_valid,
    input  logic                      rd_resp_ready,
    output wr_req_t                   s_wr_req [`SOC_WIN_COUNT],
    output logic [`SOC_WIN_COUNT-1:0] s_wr_req_valid,
    input  logic [`SOC_WIN_COUNT-1:0] s_wr_req_ready,
    input  wr_resp_t                  s_wr_resp [`SOC_WIN_COUNT],
    input  logic [`SOC_WIN_COUNT-1:0] s_wr_resp_valid,
    output logic [`SOC_WIN_COUNT-1:0] s_wr_resp_ready,
    output rd_req_t                   s_rd_req [`SOC_WIN_COUNT],
    output logic [`SOC_WIN_COUNT-1:0] s_rd_req_valid,
    input  logic [`SOC_WIN_COUNT-1:0] s_rd_req_ready,
    input  rd_resp_t                  s_rd_resp [`SOC_WIN_COUNT],
    input  logic [`SOC_WIN_COUNT-1:0] s_rd_resp_valid,
    output logic [`SOC_WIN_COUNT-1:0] s_rd_resp_ready,
    output bus_stats_t                stats
);

    localparam int SEL_W = $clog2(`SOC_WIN_COUNT);

    logic             wr_busy, wr_fwd, wr_dec, wr_take, wr_done, wr_hit;
    logic             rd_busy, rd_fwd, rd_dec, rd_take, rd_done, rd_hit;
    logic [SEL_W-1:0] wr_sel, rd_sel;
    wr_req_t          wr_q;
    rd_req_t          rd_q;

    assign wr_req_ready = !wr_busy; // one write in flight
    assign rd_req_ready = !rd_busy;
    assign wr_take = wr_req_valid && wr_req_ready;
    assign rd_take = rd_req_valid && rd_req_ready;
    assign wr_done = wr_resp_valid && wr_resp_ready;
    assign rd_done = rd_resp_valid && rd_resp_ready;
    assign wr_hit = wr_req.addr.f.win < `SOC_WIN_COUNT;
    assign rd_hit = rd_req.addr.f.win < `SOC_WIN_COUNT;

    always_ff @(posedge sys_clk) begin
        if (rst) begin
            wr_busy <= 1'b0;
            wr_fwd  <= 1'b0;
            wr_dec  <= 1'b0;
            wr_sel  <= '0;
        end else if (wr_take) begin
            wr_busy <= 1'b1;
            wr_fwd  <= wr_hit;
            wr_dec  <= !wr_hit; // answered here, no slave
            wr_sel  <= wr_req.addr.f.win[SEL_W-1:0];
        end else begin
            if (wr_fwd && s_wr_req_ready[wr_sel])
                wr_fwd <= 1'b0;
            if (wr_done) begin
                wr_busy <= 1'b0;
                wr_dec  <= 1'b0;
            end
        end
    end

    always_ff @(posedge sys_clk) begin
        if (rst) begin
            rd_busy <= 1'b0;
            rd_fwd  <= 1'b0;
            rd_dec  <= 1'b0;
            rd_sel  <= '0;
        end else if (rd_take) begin
            rd_busy <= 1'b1;
            rd_fwd  <= rd_hit;
            rd_dec  <= !rd_hit;
            rd_sel  <= rd_req.addr.f.win[SEL_W-1:0];
        end else begin
            if (rd_fwd && s_rd_req_ready[rd_sel])
                rd_fwd <= 1'b0;
            if (rd_done) begin
                rd_busy <= 1'b0;
                rd_dec  <= 1'b0;
            end
        end
    end

    always_ff @(posedge sys_clk) begin
        if (wr_take)
            wr_q <= wr_req;
        if (rd_take)
            rd_q <= rd_req;
    end

    // shared payload, per-slave valid; responses muxed by held window
    always_comb begin
        for (int i = 0; i < `SOC_WIN_COUNT; i++) begin
            s_wr_req[i] = wr_q;
            s_rd_req[i] = rd_q;
        end
        s_wr_req_valid = '0;
        s_rd_req_valid = '0;
        s_wr_resp_ready = '0;
        s_rd_resp_ready = '0;
        s_wr_req_valid[wr_sel] = wr_fwd;
        s_rd_req_valid[rd_sel] = rd_fwd;
        s_wr_resp_ready[wr_sel] = wr_busy && !wr_dec && wr_resp_ready;
        s_rd_resp_ready[rd_sel] = rd_busy && !rd_dec && rd_resp_ready;
        if (wr_dec) begin
            wr_resp.resp = RESP_DECERR;
            wr_resp_valid = 1'b1;
        end else begin
            wr_resp = s_wr_resp[wr_sel];
            wr_resp_valid = wr_busy && s_wr_resp_valid[wr_sel];
        end
        if (rd_dec) begin
            rd_resp = '{data: '0, resp: RESP_DECERR};
            rd_resp_valid = 1'b1;
        end else begin
            rd_resp = s_rd_resp[rd_sel];
            rd_resp_valid = rd_busy && s_rd_resp_valid[rd_sel];
        end
    end

    // counters wrap at 8 bits
    always_ff @(posedge sys_clk) begin
        if (rst) begin
            stats <= '0;
        end else begin
            if (wr_done)
                stats.wr_count <= stats.wr_count + 8'd1;
            if (rd_done)
                stats.rd_count <= stats.rd_count + 8'd1;
            stats.err_count <= stats.err_count
                + 8'(wr_done && wr_resp.resp != RESP_OKAY)
                + 8'(rd_done && rd_resp.resp != RESP_OKAY);
        end
    end

endmodule

/* logic/ram_slave.sv */
`timescale 1ns/1ps
`include "soc_macros.svh"

module ram_slave import soc_pkg::*; #(
    parameter int RAM_WORDS = `SOC_RAM_WORDS
) (
    input  logic     sys_clk,
    input  logic     rst,
    input  wr_req_t  wr_req,
    input  logic     wr_req_valid,
    output logic     wr_req_ready,
    output wr_resp_t wr_resp,
    output logic     wr_resp_valid,
    input  logic     wr_resp_ready,
    input  rd_req_t  rd_req,
    input  logic     rd_req_valid,
    output logic     rd_req_ready,
    output rd_resp_t rd_resp,
    output logic     rd_resp_valid,
    input  logic     rd_resp_ready
);

    localparam int IDX_W = $clog2(RAM_WORDS);
    localparam int LSB   = $clog2(`SOC_STRB_W); // byte bits

    logic [`SOC_DATA_W-1:0] mem [RAM_WORDS];
    logic [IDX_W-1:0]       wr_idx, rd_idx;
    logic                   wr_take, rd_take;

    // upper address bits ignored, so aliases wrap at the depth
    assign wr_idx = wr_req.addr.raw[LSB +: IDX_W];
    assign rd_idx = rd_req.addr.raw[LSB +: IDX_W];

    assign wr_req_ready = !wr_resp_valid;
    assign rd_req_ready = !rd_resp_valid;
    assign wr_take = wr_req_valid && wr_req_ready;
    assign rd_take = rd_req_valid && rd_req_ready;
    assign wr_resp.resp = RESP_OKAY;

    always_ff @(posedge sys_clk) begin
        if (rst) begin
            wr_resp_valid <= 1'b0;
            rd_resp_valid <= 1'b0;
        end else begin
            if (wr_take)
                wr_resp_valid <= 1'b1;
            else if (wr_resp_ready)
                wr_resp_valid <= 1'b0;
            if (rd_take)
                rd_resp_valid <= 1'b1;
            else if (rd_resp_ready)
                rd_resp_valid <= 1'b0;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (wr_take) begin
            for (int b = 0; b < `SOC_STRB_W; b++) begin
                if (wr_req.strb[b])
                    mem[wr_idx][8*b +: 8] <= wr_req.data[8*b +: 8];
            end
        end
        if (rd_take)
            rd_resp <= '{data: mem[rd_idx], resp: RESP_OKAY};
    end

endmodule

/* logic/led_reg_slave.sv */
`timescale 1ns/1ps
`include "soc_macros.svh"

module led_reg_slave import soc_pkg::*; (
    input  logic                   sys_clk,
    input  logic                   rst,
    input  wr_req_t                wr_req,
    input  logic                   wr_req_valid,
    output logic                   wr_req_ready,
    output wr_resp_t               wr_resp,
    output logic                   wr_resp_valid,
    input  logic                   wr_resp_ready,
    input  rd_req_t                rd_req,
    input  logic                   rd_req_valid,
    output logic                   rd_req_ready,
    output rd_resp_t               rd_resp,
    output logic                   rd_resp_valid,
    input  logic                   rd_resp_ready,
    output logic [`SOC_DATA_W-1:0] led_reg
);

    logic wr_take, rd_take;

    assign wr_req_ready = !wr_resp_valid;
    assign rd_req_ready = !rd_resp_valid;
    assign wr_take = wr_req_valid && wr_req_ready;
    assign rd_take = rd_req_valid && rd_req_ready;
    assign wr_resp.resp = RESP_OKAY;

    // single register, whole window decodes to it
    always_ff @(posedge sys_clk) begin
        if (rst) begin
            led_reg <= '0;
            wr_resp_valid <= 1'b0;
            rd_resp_valid <= 1'b0;
        end else begin
            if (wr_take) begin
                for (int b = 0; b < `SOC_STRB_W; b++) begin
                    if (wr_req.strb[b])
                        led_reg[8*b +: 8] <= wr_req.data[8*b +: 8];
                end
                wr_resp_valid <= 1'b1;
            end else if (wr_resp_ready) begin
                wr_resp_valid <= 1'b0;
            end
            if (rd_take)
                rd_resp_valid <= 1'b1;
            else if (rd_resp_ready)
                rd_resp_valid <= 1'b0;
        end
    end

    // rd_req address not decoded
    always_ff @(posedge sys_clk) begin
        if (rd_take)
            rd_resp <= '{data: led_reg, resp: RESP_OKAY};
    end

endmodule

/* logic/error_slave.sv */
`timescale 1ns/1ps

module error_slave import soc_pkg::*; (
    input  logic     sys_clk,
    input  logic     rst,
    input  wr_req_t  wr_req,
    input  logic     wr_req_valid,
    output logic     wr_req_ready,
    output wr_resp_t wr_resp,
    output logic     wr_resp_valid,
    input  logic     wr_resp_ready,
    input  rd_req_t  rd_req,
    input  logic     rd_req_valid,
    output logic     rd_req_ready,
    output rd_resp_t rd_resp,
    output logic     rd_resp_valid,
    input  logic     rd_resp_ready
);

    // request payload is dropped, every access fails
    assign wr_req_ready = !wr_resp_valid;
    assign rd_req_ready = !rd_resp_valid;
    assign wr_resp.resp = RESP_SLVERR;
    assign rd_resp = '{data: '0, resp: RESP_SLVERR};

    always_ff @(posedge sys_clk) begin
        if (rst) begin
            wr_resp_valid <= 1'b0;
            rd_resp_valid <= 1'b0;
        end else begin
            if (wr_req_valid && wr_req_ready)
                wr_resp_valid <= 1'b1;
            else if (wr_resp_ready)
                wr_resp_valid <= 1'b0;
            if (rd_req_valid && rd_req_ready)
                rd_resp_valid <= 1'b1;
            else if (rd_resp_ready)
                rd_resp_valid <= 1'b0;
        end
    end

endmodule

/* logic/status_display.sv */
`timescale 1ns/1ps
`include "soc_macros.svh"

module status_display import soc_pkg::*; (
    input  logic                   sys_clk,
    input  logic                   rst,
    input  logic                   btn_up,
    input  logic                   btn_down,
    input  logic [`SOC_DATA_W-1:0] led_reg,
    input  bus_stats_t             stats,
    output logic [7:0]             led8,
    output logic [3:0]             led4
);

    logic       up_q, dn_q, up_rise, dn_rise;
    logic [3:0] page, page_nxt;
    logic [7:0] bytes [`SOC_PAGE_COUNT];

    assign up_rise = btn_up && !up_q;
    assign dn_rise = btn_down && !dn_q;
    assign led4 = page;

    always_comb begin
        case ({up_rise, dn_rise})
            2'b10:   page_nxt = page + 4'd1; // wraps 15 -> 0
            2'b01:   page_nxt = page - 4'd1;
            default: page_nxt = page;        // both or neither
        endcase
    end

    always_comb begin
        for (int i = 0; i < 4; i++)
            bytes[i] = led_reg[8*i +: 8];
        bytes[4] = stats.wr_count;
        bytes[5] = stats.rd_count;
        bytes[6] = stats.err_count;
        bytes[7] = 8'h00;
        bytes[8] = `SOC_PATTERN_A;
        bytes[9] = `SOC_PATTERN_B;
        bytes[10] = `SOC_PATTERN_C;
        bytes[11] = `SOC_PATTERN_D;
        for (int i = 12; i < `SOC_PAGE_COUNT; i++)
            bytes[i] = bytes[i-4];  // patterns repeat
    end

    always_ff @(posedge sys_clk) begin
        if (rst) begin
            up_q <= 1'b0;
            dn_q <= 1'b0;
            page <= '0;
            led8 <= ~bytes[0];
        end else begin
            up_q <= btn_up;
            dn_q <= btn_down;
            page <= page_nxt;
            led8 <= ~bytes[page_nxt]; // active-low
        end
    end

endmodule

/* logic/soc_top.sv */
`timescale 1ns/1ps
`include "soc_macros.svh"

module soc_top import soc_pkg::*; (
    input  logic       sys_clk,
    input  logic       rst,
    input  wr_req_t    wr_req,
    input  logic       wr_req_valid,
    output logic       wr_req_ready,
    output wr_resp_t   wr_resp,
    output logic       wr_resp_valid,
    input  logic       wr_resp_ready,
    input  rd_req_t    rd_req,
    input  logic       rd_req_valid,
    output logic       rd_req_ready,
    output rd_resp_t   rd_resp,
    output logic       rd_resp_valid,
    input  logic       rd_resp_ready,
    input  logic       btn_up,
    input  logic       btn_down,
    output logic [7:0] led8,
    output logic [3:0] led4
);

    wr_req_t                   s_wr_req [`SOC_WIN_COUNT];
    wr_resp_t                  s_wr_resp [`SOC_WIN_COUNT];
    rd_req_t                   s_rd_req [`SOC_WIN_COUNT];
    rd_resp_t                  s_rd_resp [`SOC_WIN_COUNT];
    logic [`SOC_WIN_COUNT-1:0] s_wr_req_valid, s_wr_req_ready;
    logic [`SOC_WIN_COUNT-1:0] s_wr_resp_valid, s_wr_resp_ready;
    logic [`SOC_WIN_COUNT-1:0] s_rd_req_valid, s_rd_req_ready;
    logic [`SOC_WIN_COUNT-1:0] s_rd_resp_valid, s_rd_resp_ready;
    logic [`SOC_DATA_W-1:0]    led_reg;
    bus_stats_t                stats;

    bus_interconnect u_bus_interconnect (.*);

    // window 0, stands in for ddr
    ram_slave u_ram_slave (
        .sys_clk, .rst,
        .wr_req(s_wr_req[0]), .wr_req_valid(s_wr_req_valid[0]),
        .wr_req_ready(s_wr_req_ready[0]), .wr_resp(s_wr_resp[0]),
        .wr_resp_valid(s_wr_resp_valid[0]), .wr_resp_ready(s_wr_resp_ready[0]),
        .rd_req(s_rd_req[0]), .rd_req_valid(s_rd_req_valid[0]),
        .rd_req_ready(s_rd_req_ready[0]), .rd_resp(s_rd_resp[0]),
        .rd_resp_valid(s_rd_resp_valid[0]), .rd_resp_ready(s_rd_resp_ready[0])
    );

    error_slave u_err_slave1 (
        .sys_clk, .rst,
        .wr_req(s_wr_req[1]), .wr_req_valid(s_wr_req_valid[1]),
        .wr_req_ready(s_wr_req_ready[1]), .wr_resp(s_wr_resp[1]),
        .wr_resp_valid(s_wr_resp_valid[1]), .wr_resp_ready(s_wr_resp_ready[1]),
        .rd_req(s_rd_req[1]), .rd_req_valid(s_rd_req_valid[1]),
        .rd_req_ready(s_rd_req_ready[1]), .rd_resp(s_rd_resp[1]),
        .rd_resp_valid(s_rd_resp_valid[1]), .rd_resp_ready(s_rd_resp_ready[1])
    );

    led_reg_slave u_led_reg_slave (
        .sys_clk, .rst, .led_reg,
        .wr_req(s_wr_req[2]), .wr_req_valid(s_wr_req_valid[2]),
        .wr_req_ready(s_wr_req_ready[2]), .wr_resp(s_wr_resp[2]),
        .wr_resp_valid(s_wr_resp_valid[2]), .wr_resp_ready(s_wr_resp_ready[2]),
        .rd_req(s_rd_req[2]), .rd_req_valid(s_rd_req_valid[2]),
        .rd_req_ready(s_rd_req_ready[2]), .rd_resp(s_rd_resp[2]),
        .rd_resp_valid(s_rd_resp_valid[2]), .rd_resp_ready(s_rd_resp_ready[2])
    );

    error_slave u_err_slave3 (
        .sys_clk, .rst,
        .wr_req(s_wr_req[3]), .wr_req_valid(s_wr_req_valid[3]),
        .wr_req_ready(s_wr_req_ready[3]), .wr_resp(s_wr_resp[3]),
        .wr_resp_valid(s_wr_resp_valid[3]), .wr_resp_ready(s_wr_resp_ready[3]),
        .rd_req(s_rd_req[3]), .rd_req_valid(s_rd_req_valid[3]),
        .rd_req_ready(s_rd_req_ready[3]), .rd_resp(s_rd_resp[3]),
        .rd_resp_valid(s_rd_resp_valid[3]), .rd_resp_ready(s_rd_resp_ready[3])
    );

    status_display u_status_display (
        .sys_clk, .rst, .btn_up, .btn_down, .led_reg, .stats, .led8, .led4
    );

endmodule

/* verif/soc_props.sv */
`timescale 1ns/1ps

module soc_props import soc_pkg::*; (
    input logic     sys_clk,
    input logic     rst,
    input logic     wr_req_valid,
    input logic     wr_req_ready,
    input wr_resp_t wr_resp,
    input logic     wr_resp_valid,
    input logic     wr_resp_ready,
    input logic     rd_req_valid,
    input logic     rd_req_ready,
    input rd_resp_t rd_resp,
    input logic     rd_resp_valid,
    input logic     rd_resp_ready
);

    int assert_fails;

    // response held until taken
    wr_resp_hold: assert property (@(posedge sys_clk) disable iff (rst)
        wr_resp_valid && !wr_resp_ready |=> wr_resp_valid && $stable(wr_resp))
        else begin
            $error("write response dropped or changed under back-pressure");
            assert_fails++;
        end

    rd_resp_hold: assert property (@(posedge sys_clk) disable iff (rst)
        rd_resp_valid && !rd_resp_ready |=> rd_resp_valid && $stable(rd_resp))
        else begin
            $error("read response dropped or changed under back-pressure");
            assert_fails++;
        end

    valids_after_reset: assert property (@(posedge sys_clk)
        rst |=> !wr_resp_valid && !rd_resp_valid)
        else begin
            $error("response valid high right after reset");
            assert_fails++;
        end

    wr_busy_ready: assert property (@(posedge sys_clk) disable iff (rst)
        (wr_req_valid && wr_req_ready) || wr_resp_valid
            |=> !wr_req_ready || $past(wr_resp_valid && wr_resp_ready))
        else begin
            $error("write request ready high with a write pending");
            assert_fails++;
        end

    rd_busy_ready: assert property (@(posedge sys_clk) disable iff (rst)
        (rd_req_valid && rd_req_ready) || rd_resp_valid
            |=> !rd_req_ready || $past(rd_resp_valid && rd_resp_ready))
        else begin
            $error("read request ready high with a read pending");
            assert_fails++;
        end

endmodule

bind soc_top soc_props u_soc_props (.*);

/* verif/soc_tb.sv */
`timescale 1ns/1ps

module soc_tb import soc_pkg::*;;

    localparam int NUM_PRESSES = 20;

    typedef struct packed {
        bit          is_write;
        bit          pair;      // runs together with the next entry
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0]  strb;
        logic [31:0] exp_data;
        resp_e       exp_resp;
    } test_entry_t;

    logic       sys_clk, rst;
    wr_req_t    wr_req;
    logic       wr_req_valid, wr_req_ready, wr_resp_valid, wr_resp_ready;
    wr_resp_t   wr_resp;
    rd_req_t    rd_req;
    logic       rd_req_valid, rd_req_ready, rd_resp_valid, rd_resp_ready;
    rd_resp_t   rd_resp;
    logic       btn_up, btn_down;
    logic [7:0] led8;
    logic [3:0] led4;

    test_entry_t tbl[$];
    logic [31:0] ram_model [256];
    logic [31:0] led_model;
    logic [7:0]  model_wr, model_rd, model_err;
    logic [3:0]  page_model;
    logic [31:0] lfsr_state;
    int          cycles, limit, test_count, fail_count;
    string       wait_wr, wait_rd;

    soc_top u_soc_top (.*);

    always #10 sys_clk = ~sys_clk;

    always @(posedge sys_clk) begin
        cycles = cycles + 1;
        if (cycles >= limit) begin
            $display("timeout at cycle %0d, write waiting for %s, read waiting for %s",
                     cycles, wait_wr, wait_rd);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    function automatic logic lfsr_bit();
        logic out;
        out = lfsr_state[0];
        lfsr_state = out ? (lfsr_state >> 1) ^ 32'h8020_0003 : lfsr_state >> 1;
        return out;
    endfunction

    task automatic step();
        @(posedge sys_clk);
        #2;
    endtask

    task automatic add_wr(input bit pair, input logic [31:0] addr, data,
                          input logic [3:0] strb, input resp_e resp);
        tbl.push_back('{1'b1, pair, addr, data, strb, 32'h0, resp});
    endtask

    task automatic add_rd(input bit pair, input logic [31:0] addr, exp_data,
                          input resp_e resp);
        tbl.push_back('{1'b0, pair, addr, 32'h0, 4'h0, exp_data, resp});
    endtask

    // word index is the address above the byte bits modulo 256 words
    task automatic model_write(input logic [31:0] addr, data, input logic [3:0] strb);
        for (int b = 0; b < 4; b++) begin
            if (strb[b] && addr[31:28] == 4'h0)
                ram_model[addr[9:2]][8*b +: 8] = data[8*b +: 8];
            else if (strb[b] && addr[31:28] == 4'h2)
                led_model[8*b +: 8] = data[8*b +: 8];
        end
    endtask

    function automatic logic [31:0] model_read(input logic [31:0] addr);
        if (addr[31:28] == 4'h0)
            return ram_model[addr[9:2]];
        if (addr[31:28] == 4'h2)
            return led_model;
        return 32'h0; // error windows read zero
    endfunction

    function automatic logic [7:0] display_byte(input logic [3:0] page);
        logic [7:0] patterns [4];
        patterns = '{8'hAA, 8'h55, 8'hF0, 8'h0F};
        case (page)
            4'd0, 4'd1, 4'd2, 4'd3: return led_model[8*page +: 8];
            4'd4:    return model_wr;
            4'd5:    return model_rd;
            4'd6:    return model_err;
            4'd7:    return 8'h00;
            default: return patterns[page[1:0]];
        endcase
    endfunction

    task automatic run_entry(input int n);
        test_entry_t t;
        logic [1:0]  delay;
        logic [1:0]  got_resp;
        logic [31:0] got_data;
        bit          ok;
        t = tbl[n];
        ok = 1'b1;
        delay[1] = lfsr_bit();
        delay[0] = lfsr_bit();
        if (t.is_write) begin
            wr_req.addr.raw = t.addr;
            wr_req.data = t.data;
            wr_req.strb = t.strb;
            wr_req_valid = 1'b1;
            wait_wr = "write request ready";
            while (!wr_req_ready)
                step();
            step();
            wr_req_valid = 1'b0;
            wait_wr = "write response valid";
            while (!wr_resp_valid)
                step();
            repeat (delay) step(); // back-pressure
            wr_resp_ready = 1'b1;
            got_resp = wr_resp.resp;
            step();
            wr_resp_ready = 1'b0;
            wait_wr = "nothing";
            model_write(t.addr, t.data, t.strb);
            model_wr = model_wr + 8'd1;
        end else begin
            rd_req.addr.raw = t.addr;
            rd_req_valid = 1'b1;
            wait_rd = "read request ready";
            while (!rd_req_ready)
                step();
            step();
            rd_req_valid = 1'b0;
            wait_rd = "read response valid";
            while (!rd_resp_valid)
                step();
            repeat (delay) step();
            rd_resp_ready = 1'b1;
            got_resp = rd_resp.resp;
            got_data = rd_resp.data;
            step();
            rd_resp_ready = 1'b0;
            wait_rd = "nothing";
            model_rd = model_rd + 8'd1;
            if (model_read(t.addr) !== t.exp_data) begin
                $display("entry %0d expected read value disagrees with the model", n);
                ok = 1'b0;
            end
            if (got_data !== t.exp_data) begin
                $display("error test %0d: rd_resp.data expected %h got %h",
                         n, t.exp_data, got_data);
                ok = 1'b0;
            end
        end
        if (t.exp_resp != RESP_OKAY)
            model_err = model_err + 8'd1;
        if (got_resp !== t.exp_resp) begin
            $display("error test %0d: %s expected %h got %h", n,
                     t.is_write ? "wr_resp.resp" : "rd_resp.resp", t.exp_resp, got_resp);
            ok = 1'b0;
        end
        $display("test %0d %s %h %s", n, t.is_write ? "write" : "read", t.addr,
                 ok ? "passed" : "failed");
        test_count++;
        if (!ok)
            fail_count++;
    endtask

    task automatic press(input bit up, input bit down);
        logic [3:0] exp_page;
        logic [7:0] exp_led;
        bit         ok;
        ok = 1'b1;
        exp_page = page_model;
        if (up && !down)
            exp_page = exp_page + 4'd1;
        else if (down && !up)
            exp_page = exp_page - 4'd1;
        btn_up = up;
        btn_down = down;
        step();
        page_model = exp_page;
        exp_led = ~display_byte(exp_page);
        if (led4 !== exp_page) begin
            $display("error test %0d: led4 expected %h got %h", test_count, exp_page, led4);
            ok = 1'b0;
        end
        if (led8 !== exp_led) begin
            $display("error test %0d: led8 expected %h got %h", test_count, exp_led, led8);
            ok = 1'b0;
        end
        btn_up = 1'b0;
        btn_down = 1'b0;
        step();
        $display("test %0d button up=%0d down=%0d page %0d %s", test_count, up, down,
                 exp_page, ok ? "passed" : "failed");
        test_count++;
        if (!ok)
            fail_count++;
    endtask

    initial begin
        int i;
        sys_clk = 1'b0;
        rst = 1'b1;
        wr_req = '0;
        rd_req = '0;
        wr_req_valid = 1'b0;
        wr_resp_ready = 1'b0;
        rd_req_valid = 1'b0;
        rd_resp_ready = 1'b0;
        btn_up = 1'b0;
        btn_down = 1'b0;
        lfsr_state = 32'h8ec42260;
        led_model = '0;
        model_wr = '0;
        model_rd = '0;
        model_err = '0;
        page_model = '0;
        cycles = 0;
        test_count = 0;
        fail_count = 0;
        wait_wr = "reset";
        wait_rd = "reset";

        // ram with full and partial strobes and aliasing above 1 KB
        add_wr(0, 32'h0000_0000, 32'h1122_3344, 4'hF, RESP_OKAY);
        add_wr(0, 32'h0000_0004, 32'hAABB_CCDD, 4'hF, RESP_OKAY);
        add_wr(0, 32'h0000_0004, 32'h5566_7788, 4'h5, RESP_OKAY);
        add_rd(0, 32'h0000_0000, 32'h1122_3344, RESP_OKAY);
        add_rd(0, 32'h0000_0004, 32'hAA66_CC88, RESP_OKAY);
        add_rd(0, 32'h0000_0404, 32'hAA66_CC88, RESP_OKAY);
        add_wr(0, 32'h0ABC_0800, 32'hDEAD_BEEF, 4'h8, RESP_OKAY);
        add_rd(0, 32'h0000_0000, 32'hDE22_3344, RESP_OKAY);
        // led register
        add_wr(0, 32'h2000_0000, 32'h1234_5678, 4'hF, RESP_OKAY);
        add_wr(0, 32'h2000_0010, 32'h0000_AB00, 4'h2, RESP_OKAY);
        add_rd(0, 32'h2000_0000, 32'h1234_AB78, RESP_OKAY);
        // default slaves and decode errors
        add_wr(0, 32'h1000_0000, 32'hFFFF_FFFF, 4'hF, RESP_SLVERR);
        add_rd(0, 32'h1000_0020, 32'h0000_0000, RESP_SLVERR);
        add_wr(0, 32'h3000_0000, 32'h0101_0101, 4'hF, RESP_SLVERR);
        add_rd(0, 32'h3FFF_FFFC, 32'h0000_0000, RESP_SLVERR);
        add_wr(0, 32'h4000_0000, 32'h0202_0202, 4'hF, RESP_DECERR);
        add_rd(0, 32'h4000_0000, 32'h0000_0000, RESP_DECERR);
        add_rd(0, 32'hF000_0000, 32'h0000_0000, RESP_DECERR);
        // overlapped pairs on disjoint targets
        add_wr(1, 32'h0000_0008, 32'hCAFE_0008, 4'hF, RESP_OKAY);
        add_rd(0, 32'h0000_0000, 32'hDE22_3344, RESP_OKAY);
        add_wr(1, 32'h2000_0000, 32'h0000_00FF, 4'h1, RESP_OKAY);
        add_rd(0, 32'h0000_0008, 32'hCAFE_0008, RESP_OKAY);
        add_wr(1, 32'h1000_0000, 32'h0303_0303, 4'hF, RESP_SLVERR);
        add_rd(0, 32'h2000_0004, 32'h1234_ABFF, RESP_OKAY);
        add_wr(1, 32'h4000_0100, 32'h0404_0404, 4'hF, RESP_DECERR);
        add_rd(0, 32'h3000_0000, 32'h0000_0000, RESP_SLVERR);
        limit = 40 * tbl.size() + 20 * NUM_PRESSES + 100;

        repeat (2) @(posedge sys_clk);
        #2;
        rst = 1'b0;
        if (led4 !== 4'h0 || led8 !== 8'hFF || wr_resp_valid || rd_resp_valid
            || !wr_req_ready || !rd_req_ready) begin
            $display("error test 0: state after reset is wrong, led4 %h led8 %h", led4, led8);
            fail_count++;
        end
        $display("reset state checked");
        test_count++;

        i = 0;
        while (i < tbl.size()) begin
            if (tbl[i].pair) begin
                fork
                    run_entry(i);
                    run_entry(i + 1);
                join
                i += 2;
            end else begin
                run_entry(i);
                i += 1;
            end
        end

        wait_wr = "button test";
        wait_rd = "button test";
        press(1'b0, 1'b1); // 0 -> 15
        repeat (17) press(1'b1, 1'b0);
        press(1'b1, 1'b1); // no move
        press(1'b0, 1'b1);

        if (u_soc_top.u_soc_props.assert_fails != 0) begin
            $display("%0d bus protocol assertions failed", u_soc_top.u_soc_props.assert_fails);
            fail_count++;
        end

        $display("tests run: %0d, failed: %0d", test_count, fail_count);
        if (fail_count == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

/* verilog.f */
+incdir+logic
logic/soc_pkg.sv
logic/bus_interconnect.sv
logic/ram_slave.sv
logic/led_reg_slave.sv
logic/error_slave.sv
logic/status_display.sv
logic/soc_top.sv
verif/soc_props.sv
verif/soc_tb.sv
